//--- hw/dfd_packet_fifo.sv
// Trace packet FIFO, circular buffer with occupancy count
`timescale 1ns/100ps
`default_nettype none

module dfd_packet_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  dfd_pkg::trace_packet_u pkt_in,
    input  logic                   pop,
    output dfd_pkg::trace_packet_u head,
    output logic                   full,
    output logic                   empty
);

    localparam int cnt_width = dfd_pkg::fifo_ptr_width + 1;

    dfd_pkg::trace_packet_u              mem [dfd_pkg::fifo_depth];
    logic [dfd_pkg::fifo_ptr_width-1:0]  wr_ptr;
    logic [dfd_pkg::fifo_ptr_width-1:0]  rd_ptr;
    logic [cnt_width-1:0]                count;
    logic [cnt_width-1:0]                count_next;

    assign count_next = count + cnt_width'(push) - cnt_width'(pop);

    // Full looks at the occupancy after this edge, so a decision made
    // now still finds room when its packet arrives
    assign full  = (count_next == cnt_width'(dfd_pkg::fifo_depth));
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pkt_in;
        end
    end

    // Overrun would mean the controller let a packet through without room
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        push |-> (count != cnt_width'(dfd_pkg::fifo_depth)));

    a_no_underrun: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

endmodule

`default_nettype wire

//--- hw/dfd_pkg.sv
// Debug signal trace definitions: widths, FIFO sizing, packet formats,
// trigger actions and configuration
`default_nettype none

package dfd_pkg;

    localparam int debug_bus_width = 32;
    localparam int timestamp_width = 32;
    localparam int source_id_width = 6;
    localparam int packet_width    = 64;

    // Packet FIFO sizing
    localparam int fifo_depth      = 8;
    localparam int fifo_ptr_width  = 3;

    // Codes 2'b00 and 2'b11 are never emitted
    typedef enum logic [1:0] {
        kind_data = 2'b01,
        kind_sync = 2'b10
    } pkt_kind_e;

    // Actions from the trigger module
    typedef enum logic [1:0] {
        trig_none      = 2'b00,
        trig_trace_on  = 2'b01,
        trig_trace_off = 2'b10
    } trig_control_e;

    // Bits left over for the timestamp in a data packet
    localparam int time_lo_width =
        packet_width - $bits(pkt_kind_e) - source_id_width - debug_bus_width;

    // Bus change or pulse, low timestamp bits only
    typedef struct packed {
        pkt_kind_e                   kind;
        logic [source_id_width-1:0]  source_id;
        logic [time_lo_width-1:0]    time_lo;
        logic [debug_bus_width-1:0]  bus_value;
    } data_pkt_s;

    // Sent when tracing starts
    typedef struct packed {
        pkt_kind_e                   kind;
        logic [source_id_width-1:0]  source_id;
        logic [time_lo_width-1:0]    reserved;
        logic [timestamp_width-1:0]  timestamp;
    } sync_pkt_s;

    // Kind sits in the top bits of both views
    typedef union packed {
        data_pkt_s data;
        sync_pkt_s sync;
    } trace_packet_u;

    typedef struct packed {
        logic                        trig_enable;
        logic [source_id_width-1:0]  source_id;
    } trace_cfg_s;

endpackage

`default_nettype wire

//--- hw/dfd_sig_capture.sv
// Debug bus sampling, change detect and trace packet assembly
`timescale 1ns/100ps
`default_nettype none

module dfd_sig_capture (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [dfd_pkg::debug_bus_width-1:0]   debug_bus,
    input  logic [dfd_pkg::timestamp_width-1:0]   core_time,
    input  dfd_pkg::trace_cfg_s                   cfg,
    input  logic                                  emit_sync,
    input  logic                                  emit_data,
    output logic                                  bus_changed,
    output logic                                  pkt_push,
    output dfd_pkg::trace_packet_u                pkt
);

    logic [dfd_pkg::debug_bus_width-1:0] bus_q;
    logic [dfd_pkg::debug_bus_width-1:0] bus_prev;
    logic [dfd_pkg::timestamp_width-1:0] time_q;
    dfd_pkg::trace_packet_u              pkt_next;

    // Two-deep bus history, one-deep time
    always_ff @(posedge clk) begin
        bus_q    <= debug_bus;
        bus_prev <= bus_q;
        time_q   <= core_time;
    end

    assign bus_changed = (bus_q != bus_prev);

    // bus_prev is the value whose change raised the data request
    always_comb begin
        pkt_next = '0;
        if (emit_sync) begin
            pkt_next.sync.kind      = dfd_pkg::kind_sync;
            pkt_next.sync.source_id = cfg.source_id;
            pkt_next.sync.reserved  = '0;
            pkt_next.sync.timestamp = time_q;
        end else begin
            pkt_next.data.kind      = dfd_pkg::kind_data;
            pkt_next.data.source_id = cfg.source_id;
            pkt_next.data.time_lo   = time_q[dfd_pkg::time_lo_width-1:0];
            pkt_next.data.bus_value = bus_prev;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_push <= 1'b0;
        end else begin
            pkt_push <= emit_sync || emit_data;
        end
    end

    always_ff @(posedge clk) begin
        if (emit_sync || emit_data) begin
            pkt <= pkt_next;
        end
    end

    a_push_kind: assert property (@(posedge clk) disable iff (reset)
        pkt_push |-> (pkt.data.kind inside {dfd_pkg::kind_data, dfd_pkg::kind_sync}));

endmodule

`default_nettype wire

//--- hw/dfd_tnif.sv
// Trace network interface, one output register held until granted
`timescale 1ns/100ps
`default_nettype none

module dfd_tnif (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   empty,
    input  dfd_pkg::trace_packet_u head,
    input  logic                   tr_gnt,
    output logic                   pop,
    output logic                   tr_vld,
    output dfd_pkg::trace_packet_u tr_data
);

    // Reload when free or when the current packet leaves this cycle
    assign pop = !empty && (!tr_vld || tr_gnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            tr_vld <= 1'b0;
        end else if (pop) begin
            tr_vld <= 1'b1;
        end else if (tr_gnt) begin
            tr_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            tr_data <= head;
        end
    end

    // Packet stays put until the sink grants it
    a_hold_until_gnt: assert property (@(posedge clk) disable iff (reset)
        (tr_vld && !tr_gnt) |=> (tr_vld && $stable(tr_data)));

endmodule

`default_nettype wire

//--- hw/dfd_trace_ctrl.sv
// Trace controller: tracing state, sync/data emission with one pending
// data slot, sticky overflow on drop
`timescale 1ns/100ps
`default_nettype none

module dfd_trace_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   trace_start,
    input  logic                   trace_stop,
    input  logic                   trace_pulse,
    input  dfd_pkg::trig_control_e trig_control,
    input  dfd_pkg::trace_cfg_s    cfg,
    input  logic                   sink_stop,
    input  logic                   bus_changed,
    input  logic                   full,
    output logic                   tracing,
    output logic                   overflow,
    output logic                   emit_sync,
    output logic                   emit_data
);

    logic trig_on;
    logic trig_off;
    logic stop_evt;
    logic start_ok;
    logic sync_req;
    logic data_req;
    logic data_pend;
    logic data_want;
    logic drop;

    // Trigger actions only count when enabled
    assign trig_on  = cfg.trig_enable && (trig_control == dfd_pkg::trig_trace_on);
    assign trig_off = cfg.trig_enable && (trig_control == dfd_pkg::trig_trace_off);

    // Stop wins over a simultaneous start
    assign stop_evt = trace_stop || trig_off || sink_stop;
    assign start_ok = (trace_start || trig_on) && !stop_evt;

    assign data_want = data_req || data_pend;

    // Sync goes first, data waits one cycle behind it.
    // Full already counts the push in flight from the last emit
    assign emit_sync = sync_req && !full;
    assign emit_data = data_want && !sync_req && !full;
    assign drop      = full && (sync_req || data_want);

    always_ff @(posedge clk) begin
        if (reset) begin
            tracing   <= 1'b0;
            overflow  <= 1'b0;
            sync_req  <= 1'b0;
            data_req  <= 1'b0;
            data_pend <= 1'b0;
        end else begin
            if (stop_evt) begin
                tracing <= 1'b0;
            end else if (start_ok) begin
                tracing <= 1'b1;
            end

            sync_req <= start_ok;
            data_req <= trace_pulse || (bus_changed && tracing);

            // Hold a data request that lost to a sync or to another request
            data_pend <= !full && ((sync_req && data_want) || (data_req && data_pend));

            // Sticky until the next start
            if (start_ok) begin
                overflow <= 1'b0;
            end else if (drop) begin
                overflow <= 1'b1;
            end
        end
    end

    // A data request that is neither sent nor dropped stays pending
    a_data_kept: assert property (@(posedge clk) disable iff (reset)
        (data_want && !emit_data && !drop) |=> data_pend);

    // Overflow only clears on a start
    a_overflow_sticky: assert property (@(posedge clk) disable iff (reset)
        (overflow && !start_ok) |=> overflow);

endmodule

`default_nettype wire

//--- hw/dfd_unit.sv
// Debug signal trace unit top: controller, capture, packet FIFO, trace interface
`timescale 1ns/100ps
`default_nettype none

module dfd_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                trace_start,
    input  logic                                trace_stop,
    input  logic                                trace_pulse,
    input  dfd_pkg::trig_control_e              trig_control,
    input  dfd_pkg::trace_cfg_s                 cfg,
    input  logic [dfd_pkg::debug_bus_width-1:0] debug_bus,
    input  logic [dfd_pkg::timestamp_width-1:0] core_time,
    input  logic                                sink_stop,
    input  logic                                tr_gnt,
    output logic                                tr_vld,
    output dfd_pkg::trace_packet_u              tr_data,
    output logic                                tracing,
    output logic                                overflow
);

    logic                   bus_changed;
    logic                   emit_sync;
    logic                   emit_data;
    logic                   pkt_push;
    dfd_pkg::trace_packet_u pkt;
    logic                   full;
    logic                   empty;
    dfd_pkg::trace_packet_u head;
    logic                   pop;

    dfd_trace_ctrl trace_ctrl (
        .clk          (clk),
        .reset        (reset),
        .trace_start  (trace_start),
        .trace_stop   (trace_stop),
        .trace_pulse  (trace_pulse),
        .trig_control (trig_control),
        .cfg          (cfg),
        .sink_stop    (sink_stop),
        .bus_changed  (bus_changed),
        .full         (full),
        .tracing      (tracing),
        .overflow     (overflow),
        .emit_sync    (emit_sync),
        .emit_data    (emit_data)
    );

    dfd_sig_capture sig_capture (
        .clk         (clk),
        .reset       (reset),
        .debug_bus   (debug_bus),
        .core_time   (core_time),
        .cfg         (cfg),
        .emit_sync   (emit_sync),
        .emit_data   (emit_data),
        .bus_changed (bus_changed),
        .pkt_push    (pkt_push),
        .pkt         (pkt)
    );

    // Stands in for the packetizer
    dfd_packet_fifo packet_fifo (
        .clk    (clk),
        .reset  (reset),
        .push   (pkt_push),
        .pkt_in (pkt),
        .pop    (pop),
        .head   (head),
        .full   (full),
        .empty  (empty)
    );

    dfd_tnif tnif (
        .clk     (clk),
        .reset   (reset),
        .empty   (empty),
        .head    (head),
        .tr_gnt  (tr_gnt),
        .pop     (pop),
        .tr_vld  (tr_vld),
        .tr_data (tr_data)
    );

endmodule

`default_nettype wire

//--- tb/dfd_unit_tb.sv
// Testbench for the debug signal trace unit: LFSR stimulus, expected-packet
// queue and concurrent checks on the trace sink port
`timescale 1ns/100ps
`default_nettype none

module dfd_unit_tb;

    localparam logic [31:0] lfsr_seed = 32'ha940_c767;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic                                clk;
    logic                                reset;
    logic                                trace_start;
    logic                                trace_stop;
    logic                                trace_pulse;
    dfd_pkg::trig_control_e              trig_control;
    dfd_pkg::trace_cfg_s                 cfg;
    logic [dfd_pkg::debug_bus_width-1:0] debug_bus;
    logic [dfd_pkg::timestamp_width-1:0] core_time;
    logic                                sink_stop;
    logic                                tr_gnt;
    logic                                tr_vld;
    dfd_pkg::trace_packet_u              tr_data;
    logic                                tracing;
    logic                                overflow;

    logic [31:0]                         lfsr;
    logic                                hold_gnt;
    logic                                exp_tracing;
    logic                                overflow_allowed;
    dfd_pkg::trace_packet_u              exp_q[$];
    dfd_pkg::trace_packet_u              exp_head;
    int                                  exp_count;
    int                                  mismatch_count;
    int                                  error_count;

    dfd_unit dfd_unit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic next_random_bit();
        logic out;
        out  = lfsr[0];
        lfsr = (lfsr >> 1) ^ (out ? lfsr_taps : 32'h0);
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    // Data packets are compared without their low timestamp bits
    function automatic logic packet_matches(input dfd_pkg::trace_packet_u actual,
                                            input dfd_pkg::trace_packet_u expected);
        if (expected.sync.kind == dfd_pkg::kind_sync) begin
            return actual == expected;
        end
        return actual.data.kind == expected.data.kind
            && actual.data.source_id == expected.data.source_id
            && actual.data.bus_value == expected.data.bus_value;
    endfunction

    function automatic void refresh_head();
        exp_count = exp_q.size();
        exp_head  = (exp_count != 0) ? exp_q[0] : '0;
    endfunction

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic expect_packet(input logic is_sync, input logic [31:0] value);
        dfd_pkg::trace_packet_u p;
        p = '0;
        if (is_sync) begin
            p.sync.kind      = dfd_pkg::kind_sync;
            p.sync.source_id = cfg.source_id;
            p.sync.timestamp = value;
        end else begin
            p.data.kind      = dfd_pkg::kind_data;
            p.data.source_id = cfg.source_id;
            p.data.bus_value = value;
        end
        exp_q.push_back(p);
        refresh_head();
    endtask

    // One cycle, inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
        trace_start  = 1'b0;
        trace_stop   = 1'b0;
        trace_pulse  = 1'b0;
        trig_control = dfd_pkg::trig_none;
        core_time    = core_time + 1;
        tr_gnt       = !hold_gnt && (next_random_bit() | next_random_bit());
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic change_bus(input logic expect_pkt);
        logic [31:0] value;
        value = random_bits(32);
        if (value == debug_bus)
            value = ~value;
        debug_bus = value;
        if (expect_pkt)
            expect_packet(1'b0, value);
    endtask

    task automatic random_changes(input int n);
        repeat (n) begin
            change_bus(1'b1);
            idle(1 + int'(random_bits(2)));
        end
    endtask

    task automatic wait_status(input logic on_overflow, input logic level);
        int n;
        n = 0;
        while ((on_overflow ? overflow : tracing) !== level && n < 20) begin
            step();
            n++;
        end
        if ((on_overflow ? overflow : tracing) !== level) begin
            error_count++;
            $display("timeout at %0t waiting for %s to go %0b", $time,
                     on_overflow ? "overflow" : "tracing", level);
        end
    endtask

    // Sync carries the timestamp seen on the edge that samples the start
    task automatic start_trace();
        trace_start = 1'b1;
        exp_tracing = 1'b1;
        expect_packet(1'b1, core_time);
        idle(1);
        wait_status(1'b0, 1'b1);
    endtask

    task automatic stop_trace();
        trace_stop  = 1'b1;
        exp_tracing = 1'b0;
        idle(1);
        wait_status(1'b0, 1'b0);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_count != 0 && n < 500) begin
            step();
            n++;
        end
        if (exp_count != 0) begin
            error_count++;
            $display("timeout at %0t, %0d expected packets never granted", $time, exp_count);
        end
        idle(8);
    endtask

    always @(posedge clk) begin
        if (!reset && tr_vld && tr_gnt && exp_count != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    a_packet_value: assert property (@(posedge clk) disable iff (reset)
        (tr_vld && tr_gnt && exp_count != 0) |-> packet_matches(tr_data, exp_head))
        else report_mismatch($sformatf("granted packet %h, expected %h",
                                       $sampled(tr_data), $sampled(exp_head)));

    a_no_stray: assert property (@(posedge clk) disable iff (reset)
        tr_vld |-> (exp_count != 0))
        else begin
            error_count++;
            $display("packet presented at %0t with none expected", $time);
        end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        (tr_vld && !tr_gnt) |=> (tr_vld && $stable(tr_data)))
        else begin
            error_count++;
            $display("packet dropped or changed before grant at %0t", $time);
        end

    a_tracing: assert property (@(posedge clk) disable iff (reset)
        tracing == $past(exp_tracing))
        else report_mismatch("tracing level differs from the strobes seen");

    a_overflow_quiet: assert property (@(posedge clk) disable iff (reset)
        !overflow_allowed |-> !overflow)
        else report_mismatch("overflow raised without back-pressure");

    initial begin
        lfsr             = lfsr_seed;
        hold_gnt         = 1'b0;
        exp_tracing      = 1'b0;
        overflow_allowed = 1'b0;
        mismatch_count   = 0;
        error_count      = 0;
        reset            = 1'b1;
        trace_start      = 1'b0;
        trace_stop       = 1'b0;
        trace_pulse      = 1'b0;
        trig_control     = dfd_pkg::trig_none;
        cfg              = '{trig_enable: 1'b0, source_id: 6'h2b};
        debug_bus        = '0;
        core_time        = '0;
        sink_stop        = 1'b0;
        tr_gnt           = 1'b0;
        refresh_head();
        idle(8);
        reset = 1'b0;
        idle(2);
        assert (!tr_vld && !tracing && !overflow)
            else report_mismatch("tr_vld, tracing or overflow high after reset");

        // Bus activity alone must stay silent
        repeat (5) begin
            change_bus(1'b0);
            idle(2);
        end
        idle(3);

        start_trace();
        idle(3);
        random_changes(16);
        drain();

        // Stop, then a pulse while idle
        stop_trace();
        idle(2);
        repeat (3) begin
            change_bus(1'b0);
            idle(2);
        end
        idle(3);
        trace_pulse = 1'b1;
        expect_packet(1'b0, debug_bus);
        idle(1);
        drain();

        // Sink side stop
        start_trace();
        idle(3);
        random_changes(4);
        idle(3);
        sink_stop   = 1'b1;
        exp_tracing = 1'b0;
        idle(1);
        wait_status(1'b0, 1'b0);
        repeat (3) begin
            change_bus(1'b0);
            idle(2);
        end
        sink_stop = 1'b0;
        drain();

        // Trigger actions, masked first
        trig_control = dfd_pkg::trig_trace_on;
        idle(4);
        start_trace();
        trig_control = dfd_pkg::trig_trace_off;
        idle(4);
        stop_trace();
        drain();
        cfg.trig_enable = 1'b1;
        trig_control    = dfd_pkg::trig_trace_on;
        exp_tracing     = 1'b1;
        expect_packet(1'b1, core_time);
        idle(1);
        wait_status(1'b0, 1'b1);
        idle(3);
        random_changes(4);
        idle(3);
        trig_control = dfd_pkg::trig_trace_off;
        exp_tracing  = 1'b0;
        idle(1);
        wait_status(1'b0, 1'b0);
        drain();

        // Sink stalls: sync plus 8 data fit, the rest is lost
        hold_gnt         = 1'b1;
        tr_gnt           = 1'b0;
        overflow_allowed = 1'b1;
        start_trace();
        idle(4);
        for (int i = 0; i < 12; i++) begin
            change_bus(i < 8);
            idle(1);
        end
        idle(4);
        wait_status(1'b1, 1'b1);
        hold_gnt = 1'b0;
        drain();
        start_trace();
        wait_status(1'b1, 1'b0);
        overflow_allowed = 1'b0;
        drain();
        stop_trace();
        drain();

        $display("%0d mismatches, %0d other errors", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hw/dfd_pkg.sv
hw/dfd_trace_ctrl.sv
hw/dfd_sig_capture.sv
hw/dfd_packet_fifo.sv
hw/dfd_tnif.sv
hw/dfd_unit.sv
tb/dfd_unit_tb.sv
